/* common/scpad_pkg.sv */
`default_nettype none

package scpad_pkg;

    // dram side
    localparam int DRAM_ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 64;
    localparam int COL_IDX_WIDTH = 8;

    // burst and request ids
    localparam int ID_WIDTH = 5;
    localparam int SUB_ID_WIDTH = 3;
    // full request id is {burst id, sub id}
    localparam int REQ_ID_WIDTH = ID_WIDTH + SUB_ID_WIDTH;

    // request queues
    localparam int NUM_QUEUES = 4;
    localparam int QUEUE_SEL_WIDTH = 2;
    // one slot stays empty, so 7 usable entries
    localparam int QUEUE_DEPTH = 8;
    localparam int QUEUE_PTR_WIDTH = 3;

    // one 64-bit beat per step
    localparam int BEAT_BYTES = 8;

    // scratchpad sram
    localparam int SRAM_ADDR_WIDTH = 12;

    // dram request opcode
    typedef enum logic {
        DRAM_OP_READ,
        DRAM_OP_WRITE
    } dram_op_e;

    // one beat headed for dram
    typedef struct packed {
        logic valid;
        dram_op_e op;
        logic [REQ_ID_WIDTH-1:0] id;
        logic [DRAM_ADDR_WIDTH-1:0] dram_addr;
        logic [COL_IDX_WIDTH-1:0] dram_vector_mask;
        // zero for reads
        logic [DATA_WIDTH-1:0] wdata;
    } dram_req_t;

    // burst sequencer states
    typedef enum logic [2:0] {
        SEQ_IDLE,
        SEQ_LOAD,
        SEQ_STORE_READ,
        SEQ_STORE_DATA,
        SEQ_WAIT_DONE
    } seq_state_e;

endpackage

`default_nettype wire

/* dram_request_queue/dram_request_queue.sv */
`timescale 1ns/100ps
`default_nettype none

module dram_request_queue (
    input  logic clk,
    input  logic n_rst,
    input  logic beat_sel,
    input  logic beat_valid,
    input  scpad_pkg::dram_op_e beat_op,
    input  logic [scpad_pkg::REQ_ID_WIDTH-1:0] beat_id,
    input  logic [scpad_pkg::DRAM_ADDR_WIDTH-1:0] beat_addr,
    input  logic [scpad_pkg::COL_IDX_WIDTH-1:0] beat_mask,
    input  logic [scpad_pkg::SUB_ID_WIDTH:0] burst_len,
    input  logic sram_res_valid,
    input  logic [scpad_pkg::DATA_WIDTH-1:0] sram_rdata,
    input  logic pop,
    output logic beat_taken,
    output logic queue_full,
    output logic burst_done,
    output logic head_valid,
    output scpad_pkg::dram_req_t head_req
);
    import scpad_pkg::*;

    // circular buffer, head is oldest
    dram_req_t slots [QUEUE_DEPTH];
    logic [QUEUE_PTR_WIDTH-1:0] head;
    logic [QUEUE_PTR_WIDTH-1:0] tail;

    // beats pushed so far in this burst
    logic [SUB_ID_WIDTH:0] beat_cnt;

    logic push;
    logic data_ready;
    dram_req_t push_entry;

    // reads need nothing else, writes wait for sram data
    assign data_ready = (beat_op == DRAM_OP_READ) || sram_res_valid;

    // wraps at QUEUE_DEPTH through the pointer width
    assign queue_full = ((tail + 1'b1) == head);
    assign head_valid = (head != tail);

    assign push = beat_sel && beat_valid && data_ready && !queue_full;
    assign beat_taken = push;

    always_comb begin
        push_entry.valid = 1'b1;
        push_entry.op = beat_op;
        push_entry.id = beat_id;
        push_entry.dram_addr = beat_addr;
        push_entry.dram_vector_mask = beat_mask;
        // store data comes straight off the sram return
        if (beat_op == DRAM_OP_WRITE) begin
            push_entry.wdata = sram_rdata;
        end else begin
            push_entry.wdata = '0;
        end
    end

    // pointers and burst bookkeeping
    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            head <= '0;
            tail <= '0;
            beat_cnt <= '0;
            burst_done <= 1'b0;
        end else begin
            burst_done <= 1'b0;
            if (push) begin
                tail <= tail + 1'b1;
                // last beat of the burst
                if ((beat_cnt + 1'b1) == burst_len) begin
                    beat_cnt <= '0;
                    burst_done <= 1'b1;
                end else begin
                    beat_cnt <= beat_cnt + 1'b1;
                end
            end
            // arbiter only pops a non-empty queue
            if (pop) begin
                head <= head + 1'b1;
            end
        end
    end

    // slot contents
    always_ff @(posedge clk) begin
        if (push) begin
            slots[tail] <= push_entry;
        end
        // invalidate the slot once it left for dram
        if (pop) begin
            slots[head].valid <= 1'b0;
        end
    end

    assign head_req = slots[head];

endmodule

`default_nettype wire

/* verilog/burst_sequencer.sv */
`timescale 1ns/100ps
`default_nettype none

module burst_sequencer (
    input  logic clk,
    input  logic n_rst,
    input  logic sched_valid,
    input  logic sched_write,
    input  logic [scpad_pkg::ID_WIDTH-1:0] sched_id,
    input  logic [scpad_pkg::DRAM_ADDR_WIDTH-1:0] sched_addr,
    input  logic [scpad_pkg::COL_IDX_WIDTH-1:0] sched_mask,
    input  logic [scpad_pkg::SUB_ID_WIDTH:0] sched_num,
    input  logic [scpad_pkg::NUM_QUEUES-1:0] queue_full,
    input  logic [scpad_pkg::NUM_QUEUES-1:0] beat_taken,
    input  logic [scpad_pkg::NUM_QUEUES-1:0] burst_done,
    output logic busy,
    output logic sched_done,
    output logic sram_ren,
    output logic [scpad_pkg::SRAM_ADDR_WIDTH-1:0] sram_addr,
    output logic [scpad_pkg::NUM_QUEUES-1:0] beat_sel,
    output logic beat_valid,
    output scpad_pkg::dram_op_e beat_op,
    output logic [scpad_pkg::REQ_ID_WIDTH-1:0] beat_id,
    output logic [scpad_pkg::DRAM_ADDR_WIDTH-1:0] beat_addr,
    output logic [scpad_pkg::COL_IDX_WIDTH-1:0] beat_mask,
    output logic [scpad_pkg::SUB_ID_WIDTH:0] burst_len
);
    import scpad_pkg::*;

    seq_state_e state;
    logic [QUEUE_SEL_WIDTH-1:0] q_idx;
    logic [SUB_ID_WIDTH-1:0] beat_idx;

    // latched burst fields
    logic burst_write;
    logic [ID_WIDTH-1:0] burst_id;
    logic [DRAM_ADDR_WIDTH-1:0] burst_addr;
    logic [COL_IDX_WIDTH-1:0] burst_mask;
    logic [SUB_ID_WIDTH:0] burst_num;
    logic [SRAM_ADDR_WIDTH-1:0] sram_base;

    logic accept;
    logic last_beat;

    // pulses while busy are dropped
    assign accept = sched_valid && (state == SEQ_IDLE);
    assign busy = (state != SEQ_IDLE);

    // beat index counts from zero, burst_num from one
    assign last_beat = (({1'b0, beat_idx} + 1'b1) == burst_num);

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            state <= SEQ_IDLE;
            q_idx <= '0;
            beat_idx <= '0;
            sched_done <= 1'b0;
        end else begin
            sched_done <= 1'b0;
            case (state)
                SEQ_IDLE: begin
                    if (accept) begin
                        // queue picked by low id bits
                        q_idx <= sched_id[QUEUE_SEL_WIDTH-1:0];
                        beat_idx <= '0;
                        state <= sched_write ? SEQ_STORE_READ : SEQ_LOAD;
                    end
                end
                SEQ_LOAD: begin
                    // one beat per cycle unless the queue is full
                    if (beat_taken[q_idx]) begin
                        if (last_beat) begin
                            state <= SEQ_WAIT_DONE;
                        end else begin
                            beat_idx <= beat_idx + 1'b1;
                        end
                    end
                end
                SEQ_STORE_READ: begin
                    // read only goes out with queue space
                    if (sram_ren) begin
                        state <= SEQ_STORE_DATA;
                    end
                end
                SEQ_STORE_DATA: begin
                    // sram data lands this cycle, queue pushes it
                    if (last_beat) begin
                        state <= SEQ_WAIT_DONE;
                    end else begin
                        beat_idx <= beat_idx + 1'b1;
                        state <= SEQ_STORE_READ;
                    end
                end
                SEQ_WAIT_DONE: begin
                    if (burst_done[q_idx]) begin
                        sched_done <= 1'b1;
                        state <= SEQ_IDLE;
                    end
                end
                default: begin
                    state <= SEQ_IDLE;
                end
            endcase
        end
    end

    // burst payload, only loaded on accept
    always_ff @(posedge clk) begin
        if (accept) begin
            burst_write <= sched_write;
            burst_id <= sched_id;
            burst_addr <= sched_addr;
            burst_mask <= sched_mask;
            burst_num <= sched_num;
            sram_base <= SRAM_ADDR_WIDTH'(sched_addr / BEAT_BYTES);
        end
    end

    // sram read for the current store beat
    assign sram_ren = (state == SEQ_STORE_READ) && !queue_full[q_idx];
    assign sram_addr = sram_base + SRAM_ADDR_WIDTH'(beat_idx);

    // shared beat bus
    assign beat_sel = NUM_QUEUES'(1) << q_idx;
    assign beat_valid = (state == SEQ_LOAD) || (state == SEQ_STORE_DATA);
    assign beat_op = burst_write ? DRAM_OP_WRITE : DRAM_OP_READ;
    assign beat_id = {burst_id, beat_idx};
    // 8 bytes per beat
    assign beat_addr = burst_addr + DRAM_ADDR_WIDTH'(beat_idx * BEAT_BYTES);
    assign beat_mask = burst_mask;
    assign burst_len = burst_num;

endmodule

`default_nettype wire

/* verilog/dram_req_arbiter.sv */
`timescale 1ns/100ps
`default_nettype none

module dram_req_arbiter (
    input  logic clk,
    input  logic n_rst,
    input  logic [scpad_pkg::NUM_QUEUES-1:0] head_valid,
    input  scpad_pkg::dram_req_t [scpad_pkg::NUM_QUEUES-1:0] head_req,
    input  logic dram_stall,
    output logic [scpad_pkg::NUM_QUEUES-1:0] pop,
    output scpad_pkg::dram_req_t dram_req
);
    import scpad_pkg::*;

    // queue granted most recently
    logic [QUEUE_SEL_WIDTH-1:0] last_grant;

    logic [QUEUE_SEL_WIDTH-1:0] cand;
    logic [QUEUE_SEL_WIDTH-1:0] grant_idx;
    logic grant_found;
    logic grant;

    // search starts one past the last grant
    always_comb begin
        grant_found = 1'b0;
        grant_idx = last_grant;
        cand = last_grant;
        for (int off = 1; off <= NUM_QUEUES; off++) begin
            // index wraps through its width
            cand = last_grant + QUEUE_SEL_WIDTH'(off);
            if (!grant_found && head_valid[cand]) begin
                grant_found = 1'b1;
                grant_idx = cand;
            end
        end
    end

    // stall blocks issue and pop alike
    assign grant = grant_found && !dram_stall;

    always_comb begin
        pop = '0;
        dram_req = '0;
        if (grant) begin
            pop[grant_idx] = 1'b1;
            dram_req = head_req[grant_idx];
            dram_req.valid = 1'b1;
        end
    end

    // rotate priority after each issue
    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            // queue 0 gets first pick out of reset
            last_grant <= QUEUE_SEL_WIDTH'(NUM_QUEUES - 1);
        end else if (grant) begin
            last_grant <= grant_idx;
        end
    end

endmodule

`default_nettype wire

/* verilog/scpad_backend.sv */
`timescale 1ns/100ps
`default_nettype none

module scpad_backend (
    input  logic clk,
    input  logic n_rst,
    input  logic sched_valid,
    input  logic sched_write,
    input  logic [scpad_pkg::ID_WIDTH-1:0] sched_id,
    input  logic [scpad_pkg::DRAM_ADDR_WIDTH-1:0] sched_addr,
    input  logic [scpad_pkg::COL_IDX_WIDTH-1:0] sched_mask,
    input  logic [scpad_pkg::SUB_ID_WIDTH:0] sched_num,
    input  logic sram_res_valid,
    input  logic [scpad_pkg::DATA_WIDTH-1:0] sram_rdata,
    input  logic dram_stall,
    output logic busy,
    output logic sched_done,
    output logic sram_ren,
    output logic [scpad_pkg::SRAM_ADDR_WIDTH-1:0] sram_addr,
    output scpad_pkg::dram_req_t dram_req
);
    import scpad_pkg::*;

    // shared beat bus from the sequencer
    logic [NUM_QUEUES-1:0] beat_sel;
    logic beat_valid;
    dram_op_e beat_op;
    logic [REQ_ID_WIDTH-1:0] beat_id;
    logic [DRAM_ADDR_WIDTH-1:0] beat_addr;
    logic [COL_IDX_WIDTH-1:0] beat_mask;
    logic [SUB_ID_WIDTH:0] burst_len;

    // per queue status back to the sequencer
    logic [NUM_QUEUES-1:0] beat_taken;
    logic [NUM_QUEUES-1:0] queue_full;
    logic [NUM_QUEUES-1:0] burst_done;

    // queue heads toward the arbiter
    logic [NUM_QUEUES-1:0] head_valid;
    dram_req_t [NUM_QUEUES-1:0] head_req;
    logic [NUM_QUEUES-1:0] pop;

    burst_sequencer seq_i (
        .clk         (clk),
        .n_rst       (n_rst),
        .sched_valid (sched_valid),
        .sched_write (sched_write),
        .sched_id    (sched_id),
        .sched_addr  (sched_addr),
        .sched_mask  (sched_mask),
        .sched_num   (sched_num),
        .queue_full  (queue_full),
        .beat_taken  (beat_taken),
        .burst_done  (burst_done),
        .busy        (busy),
        .sched_done  (sched_done),
        .sram_ren    (sram_ren),
        .sram_addr   (sram_addr),
        .beat_sel    (beat_sel),
        .beat_valid  (beat_valid),
        .beat_op     (beat_op),
        .beat_id     (beat_id),
        .beat_addr   (beat_addr),
        .beat_mask   (beat_mask),
        .burst_len   (burst_len)
    );

    // one queue per low id value
    for (genvar q = 0; q < NUM_QUEUES; q++) begin : g_queue
        dram_request_queue queue_i (
            .clk            (clk),
            .n_rst          (n_rst),
            .beat_sel       (beat_sel[q]),
            .beat_valid     (beat_valid),
            .beat_op        (beat_op),
            .beat_id        (beat_id),
            .beat_addr      (beat_addr),
            .beat_mask      (beat_mask),
            .burst_len      (burst_len),
            .sram_res_valid (sram_res_valid),
            .sram_rdata     (sram_rdata),
            .pop            (pop[q]),
            .beat_taken     (beat_taken[q]),
            .queue_full     (queue_full[q]),
            .burst_done     (burst_done[q]),
            .head_valid     (head_valid[q]),
            .head_req       (head_req[q])
        );
    end

    dram_req_arbiter arb_i (
        .clk        (clk),
        .n_rst      (n_rst),
        .head_valid (head_valid),
        .head_req   (head_req),
        .dram_stall (dram_stall),
        .pop        (pop),
        .dram_req   (dram_req)
    );

endmodule

`default_nettype wire

/* sim/tb_scpad_backend.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_scpad_backend;
    import scpad_pkg::*;

    localparam int NUM_ROWS = 10;
    localparam int WAIT_LIMIT = 500;
    localparam int LONG_STALL_CYCLES = 60;
    localparam logic [DATA_WIDTH-1:0] SRAM_PATTERN = 64'h5a3c_96e1_0f87_d2b4;

    // one scheduler burst and the queue it has to land in
    typedef struct packed {
        logic write;
        logic [ID_WIDTH-1:0] id;
        logic [DRAM_ADDR_WIDTH-1:0] addr;
        logic [COL_IDX_WIDTH-1:0] mask;
        logic [SUB_ID_WIDTH:0] num;
        logic [QUEUE_SEL_WIDTH-1:0] exp_q;
        logic long_stall;
    } burst_row_t;

    logic clk = 1'b0;
    logic n_rst;
    logic sched_valid;
    logic sched_write;
    logic [ID_WIDTH-1:0] sched_id;
    logic [DRAM_ADDR_WIDTH-1:0] sched_addr;
    logic [COL_IDX_WIDTH-1:0] sched_mask;
    logic [SUB_ID_WIDTH:0] sched_num;
    logic sram_res_valid;
    logic [DATA_WIDTH-1:0] sram_rdata;
    logic dram_stall;
    logic busy;
    logic sched_done;
    logic sram_ren;
    logic [SRAM_ADDR_WIDTH-1:0] sram_addr;
    dram_req_t dram_req;

    burst_row_t rows [NUM_ROWS];
    // expected requests per queue, in issue order
    dram_req_t exp_q [NUM_QUEUES][$];
    // expected sram read addresses of all store beats
    logic [SRAM_ADDR_WIDTH-1:0] exp_sram [$];
    int value_errors = 0;
    int timeout_errors = 0;
    int done_count = 0;
    int stall_hold = 0;
    logic long_stall_req;
    logic [31:0] lfsr_state = 32'h4bde_358d;
    logic stall_a;
    logic stall_b;
    logic [QUEUE_SEL_WIDTH-1:0] mon_q;
    logic busy_last = 1'b0;
    bit ok;

    scpad_backend dut_i (.*);

    always #2 clk = ~clk;

    // sram contents depend on the whole address
    function automatic logic [DATA_WIDTH-1:0] sram_value(
        input logic [SRAM_ADDR_WIDTH-1:0] a
    );
        return SRAM_PATTERN ^ DATA_WIDTH'(a);
    endfunction

    // galois form with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    function automatic bit queues_empty();
        for (int q = 0; q < NUM_QUEUES; q++) begin
            if (exp_q[q].size() != 0) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    // one request per beat with the beat index as sub id
    task automatic build_expected();
        dram_req_t req;
        logic [SRAM_ADDR_WIDTH-1:0] beat_sram;
        for (int r = 0; r < NUM_ROWS; r++) begin
            for (int b = 0; b < int'(rows[r].num); b++) begin
                req.valid = 1'b1;
                req.op = rows[r].write ? DRAM_OP_WRITE : DRAM_OP_READ;
                req.id = {rows[r].id, SUB_ID_WIDTH'(b)};
                req.dram_addr = rows[r].addr + DRAM_ADDR_WIDTH'(b * BEAT_BYTES);
                req.dram_vector_mask = rows[r].mask;
                // sram word index from the byte address wraps in 12 bits
                beat_sram = SRAM_ADDR_WIDTH'(rows[r].addr / BEAT_BYTES) + SRAM_ADDR_WIDTH'(b);
                req.wdata = rows[r].write ? sram_value(beat_sram) : '0;
                exp_q[rows[r].exp_q].push_back(req);
                if (rows[r].write) begin
                    exp_sram.push_back(beat_sram);
                end
            end
        end
    endtask

    task automatic check_req(input dram_req_t got, input dram_req_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("[ERROR] %0t: request op %0d id %h addr %h mask %h wdata %h", $time,
                got.op, got.id, got.dram_addr, got.dram_vector_mask, got.wdata);
            $display("[ERROR] %0t: expected op %0d id %h addr %h mask %h wdata %h", $time,
                exp.op, exp.id, exp.dram_addr, exp.dram_vector_mask, exp.wdata);
        end
    endtask

    task automatic check_done(input int got, input int exp);
        if (got != exp) begin
            value_errors++;
            $display("[ERROR] %0t: %0d sched_done pulses, expected %0d", $time, got, exp);
        end
    endtask

    task automatic check_sram_addr(
        input logic [SRAM_ADDR_WIDTH-1:0] got,
        input logic [SRAM_ADDR_WIDTH-1:0] exp
    );
        if (got !== exp) begin
            value_errors++;
            $display("[ERROR] %0t: sram_addr %h, expected %h", $time, got, exp);
        end
    endtask

    task automatic check_level(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            value_errors++;
            $display("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_idle_outputs(input string when);
        check_level(busy, 1'b0, {"busy ", when});
        check_level(sched_done, 1'b0, {"sched_done ", when});
        check_level(sram_ren, 1'b0, {"sram_ren ", when});
        check_level(dram_req.valid, 1'b0, {"dram_req.valid ", when});
    endtask

    task automatic wait_busy_low(input int row, output bit done_ok);
        int cycles;
        cycles = 0;
        done_ok = 1'b0;
        while (!done_ok && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            done_ok = !busy;
            cycles++;
        end
        if (!done_ok) begin
            timeout_errors++;
            $display("timeout: busy still high after %0d cycles before row %0d", cycles, row);
        end
    endtask

    // counters change at negedge, so look at them on the rising edge
    task automatic wait_drain(output bit done_ok);
        int cycles;
        cycles = 0;
        done_ok = 1'b0;
        while (!done_ok && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            done_ok = (done_count == NUM_ROWS) && queues_empty();
            cycles++;
        end
        if (!done_ok) begin
            timeout_errors++;
            $display("timeout: queues did not drain, %0d of %0d bursts done",
                done_count, NUM_ROWS);
        end
    endtask

    // sram answers one cycle after the read strobe
    always @(posedge clk) begin
        sram_res_valid <= sram_ren;
        if (sram_ren) begin
            sram_rdata <= sram_value(sram_addr);
        end
    end

    // random stall with a long hold when a row asks for it
    always @(posedge clk) begin
        if (!n_rst) begin
            dram_stall <= 1'b0;
        end else if (long_stall_req) begin
            stall_hold = LONG_STALL_CYCLES;
            dram_stall <= 1'b1;
        end else if (stall_hold != 0) begin
            stall_hold = stall_hold - 1;
            dram_stall <= 1'b1;
        end else begin
            // one step per bit, stall when both bits are set
            stall_a = lfsr_state[0];
            lfsr_state = lfsr_next(lfsr_state);
            stall_b = lfsr_state[0];
            lfsr_state = lfsr_next(lfsr_state);
            dram_stall <= stall_a & stall_b;
        end
    end

    // dut outputs settle by mid cycle
    always @(negedge clk) begin
        if (n_rst && sched_done) begin
            done_count++;
            // busy drops on the same edge as the done pulse
            check_level(busy_last, 1'b1, "busy before sched_done");
            check_level(busy, 1'b0, "busy during sched_done");
        end
        if (n_rst && sram_ren) begin
            if (exp_sram.size() == 0) begin
                value_errors++;
                $display("[ERROR] %0t: unexpected sram read at %h", $time, sram_addr);
            end else begin
                check_sram_addr(sram_addr, exp_sram.pop_front());
            end
        end
        if (n_rst && dram_req.valid) begin
            check_level(dram_stall, 1'b0, "dram_stall during an issued request");
            // queue follows the low burst id bits
            mon_q = dram_req.id[SUB_ID_WIDTH +: QUEUE_SEL_WIDTH];
            if (exp_q[mon_q].size() == 0) begin
                value_errors++;
                $display("[ERROR] %0t: unexpected request id %h", $time, dram_req.id);
            end else begin
                check_req(dram_req, exp_q[mon_q].pop_front());
            end
        end
        busy_last = busy;
    end

    initial begin
        n_rst = 1'b0;
        sched_valid = 1'b0;
        sched_write = 1'b0;
        sched_id = '0;
        sched_addr = '0;
        sched_mask = '0;
        sched_num = '0;
        sram_res_valid = 1'b0;
        sram_rdata = '0;
        dram_stall = 1'b0;
        long_stall_req = 1'b0;
        // write, id, addr, mask, num, queue, long stall
        rows[0] = {1'b0, 5'h01, 32'h0000_1000, 8'hff, 4'd4, 2'd1, 1'b0};
        rows[1] = {1'b1, 5'h02, 32'h0000_2040, 8'h0f, 4'd3, 2'd2, 1'b0};
        rows[2] = {1'b0, 5'h04, 32'h0001_0008, 8'h81, 4'd1, 2'd0, 1'b0};
        rows[3] = {1'b1, 5'h07, 32'h0000_3ff8, 8'h3c, 4'd8, 2'd3, 1'b0};
        rows[4] = {1'b0, 5'h05, 32'h0000_4000, 8'haa, 4'd8, 2'd1, 1'b1};
        rows[5] = {1'b1, 5'h09, 32'h0000_5100, 8'h55, 4'd8, 2'd1, 1'b1};
        rows[6] = {1'b0, 5'h0e, 32'h8000_0010, 8'h01, 4'd2, 2'd2, 1'b0};
        rows[7] = {1'b1, 5'h13, 32'h0000_0ff0, 8'hf0, 4'd5, 2'd3, 1'b0};
        rows[8] = {1'b0, 5'h1c, 32'h0000_7000, 8'hc3, 4'd6, 2'd0, 1'b0};
        // sram index wraps past the top of the scratchpad
        rows[9] = {1'b1, 5'h1f, 32'h0000_fff8, 8'h7e, 4'd7, 2'd3, 1'b0};
        build_expected();

        // five cycles in reset
        repeat (4) @(posedge clk);
        @(negedge clk);
        check_idle_outputs("in reset");
        @(posedge clk);
        n_rst <= 1'b1;
        @(negedge clk);
        check_idle_outputs("after reset");

        ok = 1'b1;
        for (int r = 0; r < NUM_ROWS && ok; r++) begin
            wait_busy_low(r, ok);
            if (ok) begin
                @(posedge clk);
                sched_valid <= 1'b1;
                sched_write <= rows[r].write;
                sched_id <= rows[r].id;
                sched_addr <= rows[r].addr;
                sched_mask <= rows[r].mask;
                sched_num <= rows[r].num;
                long_stall_req <= rows[r].long_stall;
                @(posedge clk);
                sched_valid <= 1'b0;
                long_stall_req <= 1'b0;
                // busy one cycle after the accepting edge
                @(negedge clk);
                check_level(busy, 1'b1, "busy after accept");
            end
        end
        if (ok) begin
            wait_drain(ok);
        end
        if (ok) begin
            // stray requests would show up in this quiet period
            repeat (20) @(posedge clk);
            check_done(done_count, NUM_ROWS);
        end

        $display("errors: %0d value mismatches, %0d timeouts", value_errors, timeout_errors);
        if (value_errors == 0 && timeout_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* scpad_be.f */
common/scpad_pkg.sv
dram_request_queue/dram_request_queue.sv
verilog/burst_sequencer.sv
verilog/dram_req_arbiter.sv
verilog/scpad_backend.sv
sim/tb_scpad_backend.sv

/* Bender.yml */
package:
  name: scpad_be

sources:
  - common/scpad_pkg.sv
  - dram_request_queue/dram_request_queue.sv
  - verilog/burst_sequencer.sv
  - verilog/dram_req_arbiter.sv
  - verilog/scpad_backend.sv
  - target: simulation
    files:
      - sim/tb_scpad_backend.sv
